//--- boot_rom.hex
// boot rom image, one hex byte per line, address 0 first
f3
31
00
f0
c3
10
00
3e
55
d3
a8
76
18
fe
00
ff

//--- msx_bus_bridge.f
design/msx_bus_pkg.sv
design/pin_sync.sv
design/addr_demux.sv
design/slot_regs.sv
design/bus_decode.sv
design/boot_rom.sv
design/bus_isolation.sv
design/msx_bus_bridge.sv
testbench/tb_msx_bus_bridge.sv

//--- Bender.yml
package:
  name: msx_bus_bridge

# boot_rom.hex in the project root is loaded by boot_rom at elaboration
sources:
  - design/msx_bus_pkg.sv
  - design/pin_sync.sv
  - design/addr_demux.sv
  - design/slot_regs.sv
  - design/bus_decode.sv
  - design/boot_rom.sv
  - design/bus_isolation.sv
  - design/msx_bus_bridge.sv
  - target: test
    files:
      - testbench/tb_msx_bus_bridge.sv

//--- testbench/tb_msx_bus_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module tb_msx_bus_bridge;

    localparam int FILTER_LEN  = 3;
    localparam int TON         = 5;
    localparam int TP          = 2;
    localparam int ISO_DELAY   = 2;
    localparam int ROM_ADDR_W  = 4;
    localparam int WAIT_LIMIT  = 100;  // cycles per wait loop
    localparam int CLK_TOGGLES = 4;

    logic                   clk_108m;
    logic                   bus_reset_n;
    logic                   ext_wait_n;
    logic                   ext_int_n;
    logic                   ext_clk_3m6;
    msx_bus_pkg::data_t     ext_data_in;
    msx_bus_pkg::cpu_bus_t  cpu_bus;
    msx_bus_pkg::data_t     cpu_dout;
    msx_bus_pkg::data_t     cpu_din;
    msx_bus_pkg::cpu_ctrl_t cpu_ctrl;
    msx_bus_pkg::ext_ctrl_t ext_ctrl;
    msx_bus_pkg::data_t     ext_mp;
    msx_bus_pkg::data_t     ext_data_out;
    msx_bus_pkg::msel_t     ext_msel;
    logic                   ext_data_oe;

    msx_bus_pkg::data_t rom_image [2**ROM_ADDR_W];  // expected rom contents
    string test_name;
    int    error_count;
    int    check_count;
    int    test_count;
    int    errors_at_start;

    msx_bus_bridge #(
        .FILTER_LEN(FILTER_LEN), .TON(TON), .TP(TP),
        .ISO_DELAY(ISO_DELAY), .ROM_ADDR_W(ROM_ADDR_W)
    ) i_msx_bus_bridge (
        .clk_108m, .bus_reset_n, .ext_wait_n, .ext_int_n, .ext_clk_3m6,
        .ext_data_in, .cpu_bus, .cpu_dout, .cpu_din, .cpu_ctrl, .ext_ctrl,
        .ext_mp, .ext_data_out, .ext_msel, .ext_data_oe
    );

    initial begin
        clk_108m = 1'b0;
        forever #4 clk_108m = ~clk_108m;
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %s: %s expected %0h actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("%s: %s", test_name, what);
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        test_count++;
    endtask

    task automatic end_test();
        if (error_count == errors_at_start) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    function automatic msx_bus_pkg::cpu_bus_t bus_word(input msx_bus_pkg::addr_t addr,
            input logic mreq_n, input logic iorq_n, input logic rd_n,
            input logic wr_n, input logic rfsh_n);
        msx_bus_pkg::cpu_bus_t b;
        b.addr   = addr;
        b.mreq_n = mreq_n;
        b.iorq_n = iorq_n;
        b.rd_n   = rd_n;
        b.wr_n   = wr_n;
        b.m1_n   = 1'b1;   // fetches clear it afterwards
        b.rfsh_n = rfsh_n;
        return b;
    endfunction

    task automatic drive_bus(input msx_bus_pkg::cpu_bus_t b);
        @(posedge clk_108m);
        cpu_bus <= b;
    endtask

    // release all strobes but keep the address so the demux stays quiet
    task automatic idle_bus(input int cycles);
        @(posedge clk_108m);
        cpu_bus <= bus_word(cpu_bus.addr, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
        repeat (cycles) @(posedge clk_108m);
    endtask

    task automatic io_write(input msx_bus_pkg::data_t port, input msx_bus_pkg::data_t value);
        @(posedge clk_108m);
        cpu_dout <= value;
        cpu_bus  <= bus_word({8'h00, port}, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1);
        @(negedge clk_108m);
        check_value("ext iorq_n on i/o write", 0, ext_ctrl.iorq_n);
        repeat (2) @(posedge clk_108m);
        idle_bus(2);
    endtask

    task automatic wait_for_din(input msx_bus_pkg::data_t value);
        int waited;
        waited = 0;
        @(negedge clk_108m);
        while (cpu_din !== value && waited < WAIT_LIMIT) begin
            @(negedge clk_108m);
            waited++;
        end
        check_value("cpu_din", value, cpu_din);
    endtask

    task automatic wait_int_level(input logic level);
        int waited;
        waited = 0;
        @(negedge clk_108m);
        while (cpu_ctrl.int_n !== level && waited < WAIT_LIMIT) begin
            @(negedge clk_108m);
            waited++;
        end
        check_value("cpu_ctrl.int_n", level, cpu_ctrl.int_n);
    endtask

    // counts negedges until the external strobe goes low including the current one
    task automatic wait_ext_low(input logic is_write, output int waited);
        waited = 0;
        while (((is_write ? ext_ctrl.wr_n : ext_ctrl.rd_n) !== 1'b0)
               && waited < WAIT_LIMIT) begin
            @(negedge clk_108m);
            waited++;
        end
        check_value(is_write ? "ext wr_n" : "ext rd_n", 0,
                    is_write ? ext_ctrl.wr_n : ext_ctrl.rd_n);
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic reset_state();
        start_test("reset_state");
        @(posedge clk_108m);
        cpu_bus <= bus_word(16'h0000, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);  // strobes held low in reset
        repeat (3) @(posedge clk_108m);
        @(negedge clk_108m);
        check_value("ext_msel in reset", 2'b00, ext_msel);
        check_value("ext rd_n in reset", 1, ext_ctrl.rd_n);
        check_value("ext wr_n in reset", 1, ext_ctrl.wr_n);
        @(posedge clk_108m);
        bus_reset_n <= 1'b1;
        cpu_bus     <= bus_word(16'h0000, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
        drive_bus(bus_word(16'h0005, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1));
        @(negedge clk_108m);
        check_value("ext mreq_n on rom read", 1, ext_ctrl.mreq_n);
        @(negedge clk_108m);       // rom data one cycle later
        check_value("rom data at 0005h", rom_image[5], cpu_din);
        repeat (ISO_DELAY + 1) @(negedge clk_108m);  // past the strobe delay
        check_value("ext rd_n on rom read", 1, ext_ctrl.rd_n);
        check_value("ext mreq_n held on rom read", 1, ext_ctrl.mreq_n);
        idle_bus(3);
        end_test();
    endtask

    task automatic input_filtering();
        int glitches;
        int rises;
        int falls;
        start_test("input_filtering");
        @(posedge clk_108m);
        ext_int_n <= 1'b0;
        wait_int_level(1'b0);
        @(posedge clk_108m);
        ext_int_n <= 1'b1;
        wait_int_level(1'b1);

        // single cycle glitch must be swallowed
        @(posedge clk_108m);
        ext_wait_n <= 1'b0;
        @(posedge clk_108m);
        ext_wait_n <= 1'b1;
        glitches = 0;
        repeat (FILTER_LEN + 10) begin
            @(negedge clk_108m);
            if (cpu_ctrl.wait_n !== 1'b1) glitches++;
        end
        check_value("wait_n glitch cycles", 0, glitches);

        rises = 0;
        falls = 0;
        for (int i = 0; i < 2 * CLK_TOGGLES; i++) begin
            @(posedge clk_108m);
            ext_clk_3m6 <= ~ext_clk_3m6;
            repeat (8) begin
                @(negedge clk_108m);
                if (cpu_ctrl.clk_rise === 1'b1) rises++;
                if (cpu_ctrl.clk_fall === 1'b1) falls++;
            end
        end
        check_value("clk_rise count", CLK_TOGGLES, rises);
        check_value("clk_fall count", CLK_TOGGLES, falls);

        drive_bus(bus_word(16'hc000, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1));  // page 3 is never claimed
        ext_data_in <= 8'h3c;
        wait_for_din(8'h3c);
        idle_bus(3);
        end_test();
    endtask

    task automatic address_sequencing();
        msx_bus_pkg::addr_t addr;
        int hi_cycles;
        int lo_cycles;
        int waited;
        start_test("address_sequencing");
        repeat (2 * (TON + TP) + 4) @(posedge clk_108m);  // let any old sequence end
        repeat (8) begin
            addr = msx_bus_pkg::addr_t'($urandom);
            while (addr == cpu_bus.addr) begin
                addr = msx_bus_pkg::addr_t'($urandom);
            end
            drive_bus(bus_word(addr, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1));
            hi_cycles = 0;
            lo_cycles = 0;
            waited    = 0;
            while (!(lo_cycles > 0 && ext_msel == 2'b00) && waited < WAIT_LIMIT) begin
                @(negedge clk_108m);
                waited++;
                if (ext_msel[1]) begin
                    hi_cycles++;
                    check_value("ext_mp high byte", addr[15:8], ext_mp);
                end
                if (ext_msel[0]) begin
                    lo_cycles++;
                    check_value("ext_mp low byte", addr[7:0], ext_mp);
                end
            end
            if (waited >= WAIT_LIMIT) begin
                report_failure("address latch sequence did not finish in time");
            end
            check_value("high latch cycles", TON, hi_cycles);
            check_value("low latch cycles", TON, lo_cycles);
        end
        end_test();
    endtask

    task automatic slot_register();
        int                    waited;
        msx_bus_pkg::cpu_bus_t fetch;
        start_test("slot_register");
        io_write(msx_bus_pkg::PPI_PORT, 8'h55);   // every page to slot 1
        @(posedge clk_108m);
        ext_data_in <= 8'ha5;
        wait_for_din(8'ha5);
        fetch      = bus_word(16'h1234, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1);
        fetch.m1_n = 1'b0;                         // opcode fetch from slot 1
        drive_bus(fetch);
        @(negedge clk_108m);
        check_value("ext mreq_n slot 1", 0, ext_ctrl.mreq_n);
        check_value("ext m1_n on fetch", 0, ext_ctrl.m1_n);
        wait_ext_low(1'b0, waited);
        check_value("cpu_din from ext bus", 8'ha5, cpu_din);
        idle_bus(3);

        io_write(msx_bus_pkg::PPI_PORT, 8'h00);
        drive_bus(bus_word(16'h4003, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1));
        @(negedge clk_108m);
        check_value("ext mreq_n slot 0", 1, ext_ctrl.mreq_n);
        @(negedge clk_108m);
        check_value("rom data at 4003h", rom_image[16'h4003 % 16], cpu_din);
        idle_bus(3);
        end_test();
    endtask

    task automatic external_write();
        int waited;
        start_test("external_write");
        @(posedge clk_108m);
        cpu_dout <= 8'h96;
        cpu_bus  <= bus_word(16'hc010, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
        @(negedge clk_108m);
        check_value("ext_data_oe", 1, ext_data_oe);
        check_value("ext_data_out", 8'h96, ext_data_out);
        check_value("ext wr_n before delay", 1, ext_ctrl.wr_n);
        wait_ext_low(1'b1, waited);
        check_value("ext wr_n delay cycles", ISO_DELAY + 1, waited);
        @(posedge clk_108m);
        cpu_bus <= bus_word(16'hc010, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
        @(negedge clk_108m);
        check_value("ext wr_n after release", 1, ext_ctrl.wr_n);
        check_value("ext_data_oe after release", 0, ext_data_oe);
        idle_bus(3);

        // refresh on a rom address goes out unclaimed
        drive_bus(bus_word(16'h0007, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0));
        @(negedge clk_108m);
        check_value("ext mreq_n in refresh", 0, ext_ctrl.mreq_n);
        check_value("ext rfsh_n", 0, ext_ctrl.rfsh_n);
        idle_bus(3);
        end_test();
    endtask

    initial begin
        void'($urandom(32'hd246_ece1));
        bus_reset_n = 1'b0;
        ext_wait_n  = 1'b1;
        ext_int_n   = 1'b1;
        ext_clk_3m6 = 1'b0;
        ext_data_in = 8'hff;
        cpu_dout    = 8'h00;
        cpu_bus     = bus_word(16'h0000, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        $readmemh("boot_rom.hex", rom_image);

        reset_state();
        input_filtering();
        address_sequencing();
        slot_register();
        external_write();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/msx_bus_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module msx_bus_bridge #(
    parameter int FILTER_LEN = 3,
    parameter int TON        = 5,
    parameter int TP         = 2,
    parameter int ISO_DELAY  = 2,
    parameter int ROM_ADDR_W = 4
) (
    input  wire                          clk_108m,
    input  wire                          bus_reset_n,
    input  wire                          ext_wait_n,
    input  wire                          ext_int_n,
    input  wire                          ext_clk_3m6,
    input  wire msx_bus_pkg::data_t      ext_data_in,
    input  wire msx_bus_pkg::cpu_bus_t   cpu_bus,
    input  wire msx_bus_pkg::data_t      cpu_dout,
    output wire msx_bus_pkg::data_t      cpu_din,
    output wire msx_bus_pkg::cpu_ctrl_t  cpu_ctrl,
    output wire msx_bus_pkg::ext_ctrl_t  ext_ctrl,
    output wire msx_bus_pkg::data_t      ext_mp,
    output wire msx_bus_pkg::data_t      ext_data_out,
    output wire msx_bus_pkg::msel_t      ext_msel,
    output wire                          ext_data_oe
);

    msx_bus_pkg::data_t     ext_data;   // filtered data pins
    msx_bus_pkg::slot_map_t slot_map;
    msx_bus_pkg::data_t     rom_data;
    logic [ROM_ADDR_W-1:0]  rom_addr;
    logic                   rom_claim;

    pin_sync #(.FILTER_LEN(FILTER_LEN)) u_pin_sync (
        .clk_108m, .bus_reset_n, .ext_wait_n, .ext_int_n, .ext_clk_3m6,
        .ext_data_in, .cpu_ctrl, .ext_data
    );

    addr_demux #(.TON(TON), .TP(TP)) u_addr_demux (
        .clk_108m, .bus_reset_n, .addr(cpu_bus.addr), .ext_mp, .ext_msel
    );

    slot_regs u_slot_regs (
        .clk_108m, .bus_reset_n, .cpu_bus, .cpu_dout, .slot_map
    );

    bus_decode #(.ROM_ADDR_W(ROM_ADDR_W)) u_bus_decode (
        .clk_108m, .cpu_bus, .slot_map, .ext_data, .rom_data,
        .rom_addr, .rom_claim, .cpu_din
    );

    boot_rom #(.ROM_ADDR_W(ROM_ADDR_W)) u_boot_rom (
        .clk_108m, .rom_addr, .rom_data
    );

    bus_isolation #(.ISO_DELAY(ISO_DELAY)) u_bus_isolation (
        .clk_108m, .bus_reset_n, .cpu_bus, .rom_claim, .cpu_dout,
        .ext_ctrl, .ext_data_out, .ext_data_oe
    );

endmodule

`default_nettype wire

//--- design/bus_isolation.sv
`timescale 1ns/1ns
`default_nettype none

module bus_isolation #(
    parameter int ISO_DELAY = 2
) (
    input  wire                          clk_108m,
    input  wire                          bus_reset_n,
    input  wire msx_bus_pkg::cpu_bus_t   cpu_bus,
    input  wire                          rom_claim,
    input  wire msx_bus_pkg::data_t      cpu_dout,
    output msx_bus_pkg::ext_ctrl_t       ext_ctrl,
    output msx_bus_pkg::data_t           ext_data_out,
    output logic                         ext_data_oe
);

    localparam int CNT_W = (ISO_DELAY > 1) ? $clog2(ISO_DELAY) : 1;

    msx_bus_pkg::iso_state_e state;
    logic [CNT_W-1:0]        cnt;
    logic                    rd_gate_n;
    logic                    wr_gate_n;
    logic                    cpu_strobe;

    assign cpu_strobe = !cpu_bus.rd_n || !cpu_bus.wr_n;

    //--------------------------------------------------------------------------
    // strobe delay, release is immediate through the OR below
    //--------------------------------------------------------------------------
    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            state     <= msx_bus_pkg::ISO_IDLE;
            cnt       <= '0;
            rd_gate_n <= 1'b1;
            wr_gate_n <= 1'b1;
        end else begin
            case (state)
                msx_bus_pkg::ISO_IDLE: begin
                    cnt       <= '0;
                    rd_gate_n <= 1'b1;
                    wr_gate_n <= 1'b1;
                    if (cpu_strobe) begin
                        state <= msx_bus_pkg::ISO_ACTIVE;
                    end
                end
                msx_bus_pkg::ISO_ACTIVE: begin
                    if (cnt == CNT_W'(ISO_DELAY - 1)) begin
                        rd_gate_n <= cpu_bus.rd_n;   // open whichever is asserted
                        wr_gate_n <= cpu_bus.wr_n;
                        state     <= msx_bus_pkg::ISO_WAIT;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                msx_bus_pkg::ISO_WAIT: begin
                    if (!cpu_strobe) begin
                        rd_gate_n <= 1'b1;
                        wr_gate_n <= 1'b1;
                        state     <= msx_bus_pkg::ISO_IDLE;
                    end
                end
                default: state <= msx_bus_pkg::ISO_IDLE;
            endcase
        end
    end

    always_comb begin
        ext_ctrl.mreq_n = cpu_bus.mreq_n | rom_claim;  // local rom hides the cycle
        ext_ctrl.iorq_n = cpu_bus.iorq_n;
        ext_ctrl.rd_n   = cpu_bus.rd_n | rd_gate_n | rom_claim;
        ext_ctrl.wr_n   = cpu_bus.wr_n | wr_gate_n;
        ext_ctrl.m1_n   = cpu_bus.m1_n;
        ext_ctrl.rfsh_n = cpu_bus.rfsh_n;
    end

    assign ext_data_out = cpu_dout;
    assign ext_data_oe  = !cpu_bus.wr_n;

    rd_wr_excl_a: assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
        !(!ext_ctrl.rd_n && !ext_ctrl.wr_n))
        else $error("external rd_n and wr_n both asserted");

endmodule

`default_nettype wire

//--- design/boot_rom.sv
`timescale 1ns/1ns
`default_nettype none

module boot_rom #(
    parameter int ROM_ADDR_W = 4
) (
    input  wire                     clk_108m,
    input  wire [ROM_ADDR_W-1:0]    rom_addr,
    output msx_bus_pkg::data_t      rom_data
);

    msx_bus_pkg::data_t rom_mem [2**ROM_ADDR_W];

    initial begin
        $readmemh("boot_rom.hex", rom_mem);
    end

    always_ff @(posedge clk_108m) begin
        rom_data <= rom_mem[rom_addr];  // one cycle read
    end

endmodule

`default_nettype wire

//--- design/bus_decode.sv
`timescale 1ns/1ns
`default_nettype none

module bus_decode #(
    parameter int ROM_ADDR_W = 4
) (
    input  wire                          clk_108m,
    input  wire msx_bus_pkg::cpu_bus_t   cpu_bus,
    input  wire msx_bus_pkg::slot_map_t  slot_map,
    input  wire msx_bus_pkg::data_t      ext_data,
    input  wire msx_bus_pkg::data_t      rom_data,
    output logic [ROM_ADDR_W-1:0]        rom_addr,
    output logic                         rom_claim,
    output msx_bus_pkg::data_t           cpu_din
);

    msx_bus_pkg::page_t page;
    logic [1:0]         pri_slot;
    logic               mem_read;
    logic               claim_q;

    assign page     = cpu_bus.addr[15:14];
    assign pri_slot = slot_map[2 * page +: 2];

    // refresh cycles also drive mreq_n low, keep them out
    assign mem_read  = !cpu_bus.mreq_n && cpu_bus.rfsh_n && !cpu_bus.rd_n;
    assign rom_claim = mem_read && !cpu_bus.addr[15] && (pri_slot == 2'b00);

    // rom is mirrored over pages 0-1
    assign rom_addr = cpu_bus.addr[ROM_ADDR_W-1:0];

    // select follows the rom read latency
    always_ff @(posedge clk_108m) begin
        claim_q <= rom_claim;
    end

    assign cpu_din = claim_q ? rom_data : ext_data;

endmodule

`default_nettype wire

//--- design/slot_regs.sv
`timescale 1ns/1ns
`default_nettype none

module slot_regs (
    input  wire                          clk_108m,
    input  wire                          bus_reset_n,
    input  wire msx_bus_pkg::cpu_bus_t   cpu_bus,
    input  wire msx_bus_pkg::data_t      cpu_dout,
    output msx_bus_pkg::slot_map_t       slot_map
);

    logic ppi_write;

    // i/o write to port A8h, interrupt acknowledge excluded
    assign ppi_write = !cpu_bus.iorq_n && cpu_bus.m1_n && !cpu_bus.wr_n
                       && (cpu_bus.addr[7:0] == msx_bus_pkg::PPI_PORT);

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            slot_map <= '0;            // all pages in slot 0
        end else if (ppi_write) begin
            slot_map <= cpu_dout;
        end
    end

endmodule

`default_nettype wire

//--- design/addr_demux.sv
`timescale 1ns/1ns
`default_nettype none

module addr_demux #(
    parameter int TON = 5,
    parameter int TP  = 2   // gap before and after the byte swap
) (
    input  wire                      clk_108m,
    input  wire                      bus_reset_n,
    input  wire msx_bus_pkg::addr_t  addr,
    output msx_bus_pkg::data_t       ext_mp,
    output msx_bus_pkg::msel_t       ext_msel
);

    localparam int SEQ_LEN = 2 * TON + 2 * TP;
    localparam int CNT_W   = $clog2(SEQ_LEN);
    localparam logic [CNT_W-1:0] HI_END   = CNT_W'(TON - 1);
    localparam logic [CNT_W-1:0] LO_SWAP  = CNT_W'(TON + TP - 1);
    localparam logic [CNT_W-1:0] LO_START = CNT_W'(TON + 2 * TP - 1);
    localparam logic [CNT_W-1:0] SEQ_END  = CNT_W'(SEQ_LEN - 1);

    msx_bus_pkg::demux_state_e state;
    msx_bus_pkg::addr_t        addr_q;
    logic [CNT_W-1:0]          cnt;
    logic                      addr_valid;
    logic                      low_sel;
    logic                      addr_changed;

    assign addr_changed = !addr_valid || (addr != addr_q);
    assign ext_mp       = low_sel ? addr_q[7:0] : addr_q[15:8];

    // address held for the whole two-byte sequence
    always_ff @(posedge clk_108m) begin
        if (state == msx_bus_pkg::DEMUX_IDLE && addr_changed) begin
            addr_q <= addr;
        end
    end

    //--------------------------------------------------------------------------
    // latch sequencer
    //--------------------------------------------------------------------------
    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            state      <= msx_bus_pkg::DEMUX_IDLE;
            cnt        <= '0;
            addr_valid <= 1'b0;
            low_sel    <= 1'b0;
            ext_msel   <= 2'b00;
        end else begin
            case (state)
                msx_bus_pkg::DEMUX_IDLE: begin
                    cnt     <= '0;
                    low_sel <= 1'b0;
                    if (addr_changed) begin
                        state      <= msx_bus_pkg::DEMUX_LATCH;
                        addr_valid <= 1'b1;
                        ext_msel   <= 2'b10;  // high byte window opens
                    end else begin
                        ext_msel <= 2'b00;
                    end
                end
                msx_bus_pkg::DEMUX_LATCH: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == HI_END) begin
                        ext_msel[1] <= 1'b0;
                    end
                    if (cnt == LO_SWAP) begin
                        low_sel <= 1'b1;
                    end
                    if (cnt == LO_START) begin
                        ext_msel[0] <= 1'b1;
                    end
                    if (cnt == SEQ_END) begin
                        ext_msel <= 2'b00;
                        state    <= msx_bus_pkg::DEMUX_IDLE;
                    end
                end
                default: state <= msx_bus_pkg::DEMUX_IDLE;
            endcase
        end
    end

    msel_excl_a: assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
        !(ext_msel[1] && ext_msel[0]))
        else $error("both address latch strobes high");

endmodule

`default_nettype wire

//--- design/pin_sync.sv
`timescale 1ns/1ns
`default_nettype none

module pin_sync #(
    parameter int FILTER_LEN = 3
) (
    input  wire                      clk_108m,
    input  wire                      bus_reset_n,
    input  wire                      ext_wait_n,
    input  wire                      ext_int_n,
    input  wire                      ext_clk_3m6,
    input  wire msx_bus_pkg::data_t  ext_data_in,
    output msx_bus_pkg::cpu_ctrl_t   cpu_ctrl,
    output msx_bus_pkg::data_t       ext_data
);

    localparam int NBITS = 11;
    localparam int CNT_W = (FILTER_LEN > 1) ? $clog2(FILTER_LEN) : 1;
    localparam logic [NBITS-1:0] IDLE_LEVEL = {2'b11, 1'b0, 8'hff};

    logic [NBITS-1:0] pin_raw;
    logic [NBITS-1:0] sync_1;
    logic [NBITS-1:0] sync_2;
    logic [NBITS-1:0] filt;
    logic [CNT_W-1:0] stable_cnt [NBITS];
    logic             clk_prev;

    // bit order is wait, int, bus clock then data[7:0]
    assign pin_raw = {ext_wait_n, ext_int_n, ext_clk_3m6, ext_data_in};

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            sync_1   <= IDLE_LEVEL;
            sync_2   <= IDLE_LEVEL;
            filt     <= IDLE_LEVEL;
            clk_prev <= IDLE_LEVEL[8];
            for (int i = 0; i < NBITS; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            sync_1   <= pin_raw;
            sync_2   <= sync_1;
            clk_prev <= filt[8];
            // new level must hold FILTER_LEN samples before it is taken
            for (int i = 0; i < NBITS; i++) begin
                if (sync_2[i] == filt[i]) begin
                    stable_cnt[i] <= '0;          // glitch gone so count starts over
                end else if (stable_cnt[i] == CNT_W'(FILTER_LEN - 1)) begin
                    filt[i]       <= sync_2[i];
                    stable_cnt[i] <= '0;
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        cpu_ctrl.wait_n   = filt[10];
        cpu_ctrl.int_n    = filt[9];
        cpu_ctrl.clk_rise = filt[8] & ~clk_prev;
        cpu_ctrl.clk_fall = ~filt[8] & clk_prev;
    end

    assign ext_data = filt[7:0];

    // the filter keeps a new clock level for at least FILTER_LEN cycles
    strobe_gap_a: assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
        cpu_ctrl.clk_rise |-> !cpu_ctrl.clk_fall [*FILTER_LEN])
        else $error("bus clock fall strobe too close to rise strobe");

endmodule

`default_nettype wire

//--- design/msx_bus_pkg.sv
`default_nettype none

package msx_bus_pkg;

    typedef logic [15:0] addr_t;     // cpu address
    typedef logic [7:0]  data_t;     // one bus byte
    typedef logic [1:0]  page_t;     // addr[15:14]
    typedef logic [7:0]  slot_map_t; // two bits per page, page 0 in [1:0]
    typedef logic [1:0]  msel_t;     // [1] high byte latch, [0] low byte latch

    // cpu side of the bridge
    typedef struct packed {
        addr_t addr;
        logic  mreq_n;
        logic  iorq_n;
        logic  rd_n;
        logic  wr_n;
        logic  m1_n;
        logic  rfsh_n;
    } cpu_bus_t;

    typedef struct packed {
        logic mreq_n;
        logic iorq_n;
        logic rd_n;
        logic wr_n;
        logic m1_n;
        logic rfsh_n;
    } ext_ctrl_t;

    // filtered pins back to the cpu, strobes are one cycle wide
    typedef struct packed {
        logic wait_n;
        logic int_n;
        logic clk_rise;
        logic clk_fall;
    } cpu_ctrl_t;

    typedef enum logic {DEMUX_IDLE, DEMUX_LATCH} demux_state_e;

    typedef enum logic [1:0] {ISO_IDLE, ISO_ACTIVE, ISO_WAIT} iso_state_e;

    localparam data_t PPI_PORT = 8'ha8; // 8255 port A, primary slot select

endpackage

`default_nettype wire
